//--- hdl/daqControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdhcalDaq_consts.svh"

module daqControl (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    acqStart,    // One-cycle strobe ignored unless idle
  output sdhcalDaqPkg::pwrLines_t pwr,         // Raw power pulsing lines
  output logic                    cycleDone,   // One-cycle strobe at end of cycle
  output logic                    timeoutErr,  // Held until next acqStart
  readoutIf.control               ro
);
  import sdhcalDaqPkg::*;

  // Shared counter must cover the longer of the two waits
  localparam int MAX_WAIT = (`READOUT_TIMEOUT > `ACQ_CYCLES) ? `READOUT_TIMEOUT : `ACQ_CYCLES;
  localparam int CNT_BITS = $clog2(MAX_WAIT);

  // Power line patterns of one acquisition cycle
  localparam pwrLines_t PWR_OFF = '{pwrOnD: 1'b0, pwrOnA: 1'b0, pwrOnAdc: 1'b0, pwrOnDac: 1'b0};
  localparam pwrLines_t PWR_ALL = '{pwrOnD: 1'b1, pwrOnA: 1'b1, pwrOnAdc: 1'b1, pwrOnDac: 1'b1};
  localparam pwrLines_t PWR_DIG = '{pwrOnD: 1'b1, pwrOnA: 1'b0, pwrOnAdc: 1'b0, pwrOnDac: 1'b0};

  typedef enum logic [1:0] {
    IDLE,     // Powered down, waiting for acqStart
    ACQUIRE,  // Everything on, ASIC taking data
    READOUT,  // Digital only, chain shifting out
    DONE      // Strobe cycle before going idle
  } state_t;

  state_t              state;
  logic [CNT_BITS-1:0] cnt;       // Acquisition window or readout timeout
  logic                endPrev;   // endReadout one cycle back
  logic                endRise;
  logic                acqLast;   // Last cycle of acquisition window
  logic                roExpired; // Timeout reached in readout

  ////////////////////
  // Edge detect and compares
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      endPrev <= 1'b0;
    end else begin
      endPrev <= ro.endReadout;
    end
  end

  assign endRise   = ro.endReadout & ~endPrev;
  assign acqLast   = (cnt == CNT_BITS'(`ACQ_CYCLES - 1));
  assign roExpired = (cnt == CNT_BITS'(`READOUT_TIMEOUT - 1));

  ////////////////////
  // Sequencer FSM
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state           <= IDLE;
      cnt             <= '0;
      pwr             <= PWR_OFF;
      ro.startReadout <= 1'b0;
      cycleDone       <= 1'b0;
      timeoutErr      <= 1'b0;
    end else begin
      ro.startReadout <= 1'b0;  // Strobes default low
      cycleDone       <= 1'b0;
      case (state)
        IDLE: begin
          if (acqStart) begin
            state      <= ACQUIRE;
            cnt        <= '0;
            pwr        <= PWR_ALL;  // All four lines up next edge
            timeoutErr <= 1'b0;     // New cycle clears old error
          end
        end
        ACQUIRE: begin
          if (acqLast) begin
            state           <= READOUT;
            cnt             <= '0;       // Reuse for timeout
            pwr             <= PWR_DIG;  // Keep digital for readout
            ro.startReadout <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        READOUT: begin
          if (endRise) begin
            state     <= DONE;
            pwr       <= PWR_OFF;
            cycleDone <= 1'b1;
          end else if (roExpired) begin
            // Chain never answered so power down anyway
            state      <= DONE;
            pwr        <= PWR_OFF;
            cycleDone  <= 1'b1;
            timeoutErr <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        DONE: begin
          state <= IDLE;  // cycleDone drops here
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/ramReadout.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdhcalDaq_consts.svh"

module ramReadout (
  input  logic                       clk,
  input  logic                       rstN,
  readoutIf.sink                     ro,
  input  logic                       startReadout,  // Clears the word count
  output sdhcalDaqPkg::readoutWord_t word,
  output logic                       wordValid,     // One-cycle strobe per word
  output sdhcalDaqPkg::wordCount_t   wordCount
);
  import sdhcalDaqPkg::*;

  localparam int BIT_CNT_BITS = $clog2(`DATA_WORD_BITS);

  logic [`DATA_WORD_BITS-2:0] shiftReg;  // Bits before the last one
  logic [BIT_CNT_BITS-1:0]    bitCnt;    // Bits already taken in this word
  logic                       lastBit;   // Current dout completes a word
  readoutWord_t               fullWord;

  assign lastBit  = ro.transmitOn && (bitCnt == BIT_CNT_BITS'(`DATA_WORD_BITS - 1));
  assign fullWord = {shiftReg, ro.dout};

  ////////////////////
  // Bit counter
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bitCnt <= '0;
    end else if (!ro.transmitOn) begin
      bitCnt <= '0;  // Drops any partial word
    end else if (lastBit) begin
      bitCnt <= '0;
    end else begin
      bitCnt <= bitCnt + 1'b1;
    end
  end

  ////////////////////
  // Data path
  ////////////////////

  always_ff @(posedge clk) begin
    if (ro.transmitOn) begin
      shiftReg <= fullWord[`DATA_WORD_BITS-2:0];  // Shift left for MSB first
    end
    if (lastBit) begin
      word <= fullWord;
    end
  end

  ////////////////////
  // Strobe and word count
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wordValid <= 1'b0;
      wordCount <= '0;
    end else begin
      wordValid <= lastBit;  // Lines up with word update
      if (startReadout) begin
        wordCount <= '0;     // New readout
      end else if (lastBit) begin
        wordCount <= wordCount + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/readoutIf.sv
`timescale 1ns/1ps
`default_nettype none

// Readout path between sequencer, chain select and deserializer
interface readoutIf;

  logic startReadout;  // Strobe towards the ASIC chain
  logic endReadout;    // Chain reports its readout finished
  logic dout;          // Serial data, MSB first
  logic transmitOn;    // Qualifies dout bit by bit

  // Sequencer side
  modport control (
    output startReadout,
    input  endReadout
  );

  // Chain select side facing the pins
  modport bridge (
    input  startReadout,
    output endReadout,
    output dout,
    output transmitOn
  );

  // Deserializer only needs the data stream
  modport sink (
    input dout,
    input transmitOn
  );

endinterface

`default_nettype wire

//--- hdl/redundancy.sv
`timescale 1ns/1ps
`default_nettype none

module redundancy (
  input  logic                    powPulsingEn,  // 1 pulsing, 0 always powered
  input  logic                    selChn,        // 1 chain 1, 0 chain 2
  input  sdhcalDaqPkg::pwrLines_t pwr,           // From sequencer
  output sdhcalDaqPkg::pwrLines_t pwrPins,       // To ASIC power pins
  readoutIf.bridge                ro,
  output logic                    startReadout1,
  output logic                    startReadout2,
  input  logic                    endReadout1,
  input  logic                    endReadout2,
  input  logic                    dout1,
  input  logic                    dout2,
  input  logic                    transmitOn1,
  input  logic                    transmitOn2
);
  import sdhcalDaqPkg::*;

  localparam pwrLines_t PWR_FORCED = '{pwrOnD: 1'b1, pwrOnA: 1'b1, pwrOnAdc: 1'b1, pwrOnDac: 1'b1};

  ////////////////////
  // Power override
  ////////////////////

  assign pwrPins = powPulsingEn ? pwr : PWR_FORCED;

  ////////////////////
  // Chain steering
  ////////////////////

  // Unselected chain never sees a start
  assign startReadout1 = selChn ? ro.startReadout : 1'b0;
  assign startReadout2 = selChn ? 1'b0 : ro.startReadout;

  assign ro.endReadout = selChn ? endReadout1 : endReadout2;
  assign ro.dout       = selChn ? dout1 : dout2;                // Pin polarity kept as is
  assign ro.transmitOn = selChn ? transmitOn1 : transmitOn2;

endmodule

`default_nettype wire

//--- hdl/sdhcalDaq.sv
`timescale 1ns/1ps
`default_nettype none

module sdhcalDaq (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       powPulsingEn,  // 0 keeps ASIC fully powered
  input  logic                       selChn,        // 1 chain 1, 0 chain 2
  input  logic                       acqStart,
  output logic                       cycleDone,
  output logic                       timeoutErr,
  output sdhcalDaqPkg::readoutWord_t word,
  output logic                       wordValid,
  output sdhcalDaqPkg::wordCount_t   wordCount,
  // ASIC pins
  output logic                       pwrOnDPin,
  output logic                       pwrOnAPin,
  output logic                       pwrOnAdcPin,
  output logic                       pwrOnDacPin,
  output logic                       startReadout1,
  output logic                       startReadout2,
  input  logic                       endReadout1,
  input  logic                       endReadout2,
  input  logic                       dout1,
  input  logic                       dout2,
  input  logic                       transmitOn1,
  input  logic                       transmitOn2
);
  import sdhcalDaqPkg::*;

  pwrLines_t pwr;      // Sequencer power lines
  pwrLines_t pwrPins;  // After override

  readoutIf roBus ();

  ////////////////////
  // Sequencer
  ////////////////////

  daqControl uDaqControl (
    .clk        (clk),
    .rstN       (rstN),
    .acqStart   (acqStart),
    .pwr        (pwr),
    .cycleDone  (cycleDone),
    .timeoutErr (timeoutErr),
    .ro         (roBus.control)
  );

  ////////////////////
  // Chain select
  ////////////////////

  redundancy uRedundancy (
    .powPulsingEn  (powPulsingEn),
    .selChn        (selChn),
    .pwr           (pwr),
    .pwrPins       (pwrPins),
    .ro            (roBus.bridge),
    .startReadout1 (startReadout1),
    .startReadout2 (startReadout2),
    .endReadout1   (endReadout1),
    .endReadout2   (endReadout2),
    .dout1         (dout1),
    .dout2         (dout2),
    .transmitOn1   (transmitOn1),
    .transmitOn2   (transmitOn2)
  );

  assign pwrOnDPin   = pwrPins.pwrOnD;
  assign pwrOnAPin   = pwrPins.pwrOnA;
  assign pwrOnAdcPin = pwrPins.pwrOnAdc;
  assign pwrOnDacPin = pwrPins.pwrOnDac;

  ////////////////////
  // Deserializer
  ////////////////////

  ramReadout uRamReadout (
    .clk          (clk),
    .rstN         (rstN),
    .ro           (roBus.sink),
    .startReadout (roBus.startReadout),  // Count restarts with each readout
    .word         (word),
    .wordValid    (wordValid),
    .wordCount    (wordCount)
  );

endmodule

`default_nettype wire

//--- hdl/sdhcalDaqPkg.sv
`default_nettype none

`include "sdhcalDaq_consts.svh"

package sdhcalDaqPkg;

  ////////////////////
  // Power pulsing
  ////////////////////

  // One bit per ASIC supply domain where high means powered
  typedef struct packed {
    logic pwrOnD;    // Digital part
    logic pwrOnA;    // Analog front end
    logic pwrOnAdc;  // ADC
    logic pwrOnDac;  // DAC
  } pwrLines_t;

  ////////////////////
  // Readout data
  ////////////////////

  typedef logic [`DATA_WORD_BITS-1:0] readoutWord_t;   // One word off the chain
  typedef logic [`WORD_COUNT_BITS-1:0] wordCount_t;    // Words seen in one readout

endpackage

`default_nettype wire

//--- hdl/sdhcalDaq_consts.svh
`ifndef SDHCALDAQ_CONSTS_SVH
`define SDHCALDAQ_CONSTS_SVH

////////////////////
// Readout word format
////////////////////

// Bits per deserialized chain word
`define DATA_WORD_BITS 16

// Width of per-readout word counter
`define WORD_COUNT_BITS 8

////////////////////
// Sequencer timing
////////////////////

// Cycles with all power lines on before readout starts
`define ACQ_CYCLES 16

// Cycles to wait for end-readout before giving up
`define READOUT_TIMEOUT 200

`endif

//--- sdhcalDaq.f
+incdir+hdl
hdl/sdhcalDaqPkg.sv
hdl/readoutIf.sv
hdl/daqControl.sv
hdl/redundancy.sv
hdl/ramReadout.sv
hdl/sdhcalDaq.sv
testbench/tbSdhcalDaq.sv

//--- testbench/tbSdhcalDaq.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdhcalDaq_consts.svh"

module tbSdhcalDaq;
  import sdhcalDaqPkg::*;

  localparam int NUM_ROWS = 7;

  logic clk = 1'b0;
  logic rstN, powPulsingEn, selChn, acqStart, cycleDone, timeoutErr, wordValid;
  logic pwrOnDPin, pwrOnAPin, pwrOnAdcPin, pwrOnDacPin, startReadout1, startReadout2;
  logic endReadout1, endReadout2, dout1, dout2, transmitOn1, transmitOn2;
  readoutWord_t word;
  wordCount_t   wordCount;
  wire  [3:0]   pins = {pwrOnDPin, pwrOnAPin, pwrOnAdcPin, pwrOnDacPin};  // D, A, ADC, DAC

  ////////////////////
  // Stimulus table
  ////////////////////

  // Each row holds name, powPulsingEn, selChn, words sent and endReadout suppressed
  string rowName [NUM_ROWS] = '{"pulse chn1", "pulse chn2", "forced chn1", "timeout chn2",
                                "after timeout chn1", "forced timeout chn1", "forced chn2"};
  bit    rowPulse [NUM_ROWS] = '{1, 1, 0, 1, 1, 0, 0};
  bit    rowSel   [NUM_ROWS] = '{1, 0, 1, 0, 1, 1, 0};
  int    rowWords [NUM_ROWS] = '{4, 3, 5, 2, 3, 0, 2};
  bit    rowNoEnd [NUM_ROWS] = '{0, 0, 0, 1, 0, 1, 0};
  readoutWord_t wordTable [NUM_ROWS][8];  // Filled from $random at time zero

  integer      seed = 16;
  logic [31:0] junk;                      // Unused chain noise
  logic        modelTx = 1'b0, modelDout = 1'b0, modelEnd = 1'b0;
  int          curRow = 0, wordIdx = 0, startCnt1 = 0, startCnt2 = 0;
  bit          monitorOn = 1'b0, lastTimeout = 1'b0;

  sdhcalDaq uut (.*);

  always #50 clk = ~clk;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "stopping simulation");
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected %0h actual %0h", what, expected, actual);
      failRun("value mismatch");
    end
  endtask

  ////////////////////
  // ASIC chain model
  ////////////////////

  // Selected chain gets the model and the other one inverted transmitOn and noise
  always @(posedge clk) begin
    junk = $random(seed);
    if (selChn) begin
      transmitOn1 <= modelTx;
      dout1       <= modelDout;
      endReadout1 <= modelEnd;
      transmitOn2 <= ~modelTx;
      dout2       <= junk[0];
      endReadout2 <= junk[1];
    end else begin
      transmitOn2 <= modelTx;
      dout2       <= modelDout;
      endReadout2 <= modelEnd;
      transmitOn1 <= ~modelTx;
      dout1       <= junk[0];
      endReadout1 <= junk[1];
    end
  end

  initial begin : asicModel
    int r, w, b;
    forever begin
      @(negedge clk);
      if (startReadout1 === 1'b1 || startReadout2 === 1'b1) begin
        r = curRow;
        repeat (3) @(posedge clk);  // Chain latency before data
        for (w = 0; w < rowWords[r]; w++) begin
          for (b = `DATA_WORD_BITS - 1; b >= 0; b--) begin
            modelTx   <= 1'b1;
            modelDout <= wordTable[r][w][b];  // MSB first
            @(posedge clk);
          end
        end
        modelTx   <= 1'b0;
        modelDout <= 1'b0;
        @(posedge clk);
        if (!rowNoEnd[r]) begin
          modelEnd <= 1'b1;
          @(posedge clk);
          modelEnd <= 0;
        end
      end
    end
  end

  ////////////////////
  // Monitors
  ////////////////////

  always @(negedge clk) begin
    if (monitorOn) begin
      if (!powPulsingEn) begin
        checkValue({rowName[curRow], " forced power pins"}, 4'hF, pins);
      end
      startCnt1 += (startReadout1 === 1'b1);
      startCnt2 += (startReadout2 === 1'b1);
      if (wordValid === 1'b1) begin
        if (wordIdx >= rowWords[curRow]) begin
          failRun({rowName[curRow], ": wordValid seen with no word left to send"});
        end else begin
          checkValue({rowName[curRow], " word"}, wordTable[curRow][wordIdx], word);
          wordIdx++;
        end
      end
    end
  end

  task automatic runRow(input int r);
    int         cnt;
    logic [3:0] expDig;
    logic [3:0] expOff;
    string      tag;
    tag    = rowName[r];
    expDig = rowPulse[r] ? 4'b1000 : 4'b1111;  // Readout keeps digital only
    expOff = rowPulse[r] ? 4'b0000 : 4'b1111;
    @(posedge clk);
    powPulsingEn <= rowPulse[r];
    selChn       <= rowSel[r];
    curRow    = r;
    wordIdx   = 0;
    startCnt1 = 0;
    startCnt2 = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    checkValue({tag, " idle pins"}, expOff, pins);
    checkValue({tag, " timeoutErr held"}, lastTimeout, timeoutErr);
    @(posedge clk);
    acqStart <= 1'b1;
    @(posedge clk);
    acqStart <= 1'b0;
    @(negedge clk);
    checkValue({tag, " timeoutErr cleared"}, 0, timeoutErr);
    cnt = 0;
    // Acquisition window up to the start pulse
    while (startReadout1 !== 1'b1 && startReadout2 !== 1'b1) begin
      checkValue({tag, " acquisition pins"}, 4'hF, pins);
      cnt++;
      if (cnt > `ACQ_CYCLES + 8) begin
        failRun({tag, ": no start-readout pulse after the acquisition window"});
      end else begin
        @(negedge clk);
      end
    end
    checkValue({tag, " acquisition cycles"}, `ACQ_CYCLES, cnt);
    checkValue({tag, " readout pins"}, expDig, pins);
    @(negedge clk);
    cnt = 1;
    while (cycleDone !== 1'b1) begin
      checkValue({tag, " readout pins"}, expDig, pins);
      if (cnt > `READOUT_TIMEOUT + 8) begin
        failRun({tag, ": cycleDone never came after start-readout"});
      end else begin
        @(negedge clk);
        cnt++;
      end
    end
    checkValue({tag, " pins at cycleDone"}, expOff, pins);
    checkValue({tag, " timeoutErr"}, rowNoEnd[r], timeoutErr);
    if (rowNoEnd[r]) begin
      checkValue({tag, " timeout cycles"}, `READOUT_TIMEOUT, cnt);
    end
    checkValue({tag, " wordCount"}, rowWords[r], wordCount);
    checkValue({tag, " words seen"}, rowWords[r], wordIdx);
    checkValue({tag, " start pulses chn1"}, rowSel[r], startCnt1);
    checkValue({tag, " start pulses chn2"}, !rowSel[r], startCnt2);
    lastTimeout = rowNoEnd[r];
  endtask

  initial begin : mainSequence
    int r, w;
    rstN         = 1'b0;
    powPulsingEn = 1'b1;
    selChn       = 1'b1;
    acqStart     = 1'b0;
    endReadout1  = 1'b0;
    endReadout2  = 1'b0;
    dout1        = 1'b0;
    dout2        = 1'b0;
    transmitOn1  = 1'b0;
    transmitOn2  = 1'b0;
    for (r = 0; r < NUM_ROWS; r++) begin
      for (w = 0; w < 8; w++) begin
        wordTable[r][w] = readoutWord_t'($random(seed));
      end
    end
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    monitorOn = 1'b1;
    for (r = 0; r < NUM_ROWS; r++) begin
      runRow(r);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
